//--- files.f
design/exec_pkg.sv
design/stream_delay.sv
design/add_logic_unit.sv
design/mul_unit.sv
design/result_select.sv
design/exec_core.sv
sim/exec_core_props.sv
sim/exec_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the exec_core testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=exec_core_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_core_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN" \
    -f files.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "all tests passed" "$LOG_FILE"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- sim/exec_core_tb.sv
// Testbench for exec_core with directed and random stimulus, reference model, scoreboard and timeout
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

    // Instruction counts of the three test phases
    localparam int N_DIRECTED = 18;
    localparam int N_RANDOM   = 300;
    localparam int N_BURST    = 16;
    localparam int N_TOTAL    = N_DIRECTED + N_RANDOM + N_BURST;

    // Four cycles per instruction is far above the worst case and 200 more cover reset and drains
    localparam int TIMEOUT_CYCLES = 4 * N_TOTAL + 200;

    // Bound on the wait for outstanding results to leave the pipe
    localparam int DRAIN_CYCLES = 100;

    localparam exec_pkg::word_t MAX_POS = 32'sh7fffffff;
    localparam exec_pkg::word_t MIN_NEG = 32'sh80000000;

    // One scoreboard entry holds the expected result and the time stamps of its issue
    typedef struct packed {
        exec_pkg::exec_result_t res;
        logic [31:0]            issue_cycle;
        logic [31:0]            issue_enabled;
        logic                   strict;
    } expect_t;

    logic                   clock;
    logic                   rst_n;
    logic                   issue_valid;
    logic                   issue_ready;
    exec_pkg::exec_issue_t  issue;
    logic                   result_valid;
    logic                   result_ready;
    exec_pkg::exec_result_t result;

    integer      seed;
    integer      ready_seed;
    logic        hold_ready;
    logic        burst_active;
    logic [31:0] cycle_count;
    logic [31:0] enabled_count;
    expect_t     sb_queue [$];
    expect_t     got_entry;
    expect_t     new_entry;

    exec_core i_exec_core (
        .clock        (clock),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Expected result of one instruction from the opcode rules
    function automatic exec_pkg::exec_result_t model_result(input exec_pkg::exec_issue_t instr);
        exec_pkg::exec_result_t res;
        longint                 product;
        res.dest = instr.dest;
        product  = longint'($signed(instr.a)) * longint'($signed(instr.b));
        case (instr.opcode)
            exec_pkg::OP_ADD: res.data = instr.a + instr.b;
            exec_pkg::OP_SUB: res.data = instr.a - instr.b;
            exec_pkg::OP_AND: res.data = instr.a & instr.b;
            exec_pkg::OP_OR:  res.data = instr.a | instr.b;
            exec_pkg::OP_XOR: res.data = instr.a ^ instr.b;
            exec_pkg::OP_SLT: res.data = ($signed(instr.a) < $signed(instr.b)) ? 32'sd1 : 32'sd0;
            // Only the low word of the product survives
            exec_pkg::OP_MUL: res.data = product[31:0];
            exec_pkg::OP_MAC: res.data = product[31:0] + instr.c;
            default:          res.data = '0;
        endcase
        return res;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED: %s got 0x%08h expected 0x%08h",
                                        name, actual, expected));
        end
    endtask

    // Holds the instruction on the bus until the edge that accepts it
    task automatic send_instr(input exec_pkg::exec_issue_t instr);
        issue       <= instr;
        issue_valid <= 1'b1;
        @(posedge clock);
        while (!issue_ready) begin
            @(posedge clock);
        end
        issue_valid <= 1'b0;
    endtask

    task automatic directed_op(input exec_pkg::opcode_t op, input exec_pkg::word_t a,
                               input exec_pkg::word_t b, input exec_pkg::word_t c);
        exec_pkg::exec_issue_t instr;
        instr.opcode = op;
        instr.dest   = exec_pkg::reg_addr_t'($random(seed));
        instr.a      = a;
        instr.b      = b;
        instr.c      = c;
        send_instr(instr);
    endtask

    // An idle cycle one time in five keeps issue_valid near 80 percent
    task automatic random_op(input bit allow_gap);
        exec_pkg::exec_issue_t instr;
        if (allow_gap && ($unsigned($random(seed)) % 5) == 0) begin
            @(posedge clock);
        end
        instr.opcode = exec_pkg::opcode_t'($random(seed));
        instr.dest   = exec_pkg::reg_addr_t'($random(seed));
        instr.a      = $random(seed);
        instr.b      = $random(seed);
        instr.c      = $random(seed);
        send_instr(instr);
    endtask

    task automatic drain_results(input int max_cycles);
        int waited;
        waited = 0;
        while (sb_queue.size() != 0 && waited < max_cycles) begin
            @(posedge clock);
            waited++;
        end
    endtask

    // result_ready is high about 70 percent of the time unless held
    always @(posedge clock) begin
        if (hold_ready) begin
            result_ready <= 1'b1;
        end else begin
            result_ready <= ($unsigned($random(ready_seed)) % 10) < 7;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    // The retiring result is compared before the new issue is recorded
    always @(posedge clock) begin
        if (rst_n) begin
            if (result_valid && result_ready) begin
                if (sb_queue.size() == 0) begin
                    stop_with_failure("A result came out with no instruction outstanding");
                end else begin
                    got_entry = sb_queue.pop_front();
                    check_value("result.dest", 32'(result.dest), 32'(got_entry.res.dest));
                    check_value("result.data", result.data, got_entry.res.data);
                    // Stall cycles never count toward the pipeline depth
                    check_value("enabled_latency", enabled_count - got_entry.issue_enabled,
                                32'(exec_pkg::EXEC_LATENCY));
                    if (got_entry.strict) begin
                        check_value("burst_latency", cycle_count - got_entry.issue_cycle,
                                    32'(exec_pkg::EXEC_LATENCY));
                    end
                end
            end
            if (issue_valid && issue_ready) begin
                new_entry.res           = model_result(issue);
                new_entry.issue_cycle   = cycle_count;
                new_entry.issue_enabled = enabled_count;
                new_entry.strict        = burst_active;
                sb_queue.push_back(new_entry);
            end
            if (issue_ready) begin
                enabled_count <= enabled_count + 1;
            end
        end
    end

    initial begin
        seed          = 32'h1c59c0e2;
        ready_seed    = seed ^ 32'h5a5a5a5a;
        rst_n         = 1'b0;
        issue_valid   = 1'b0;
        issue         = '0;
        result_ready  = 1'b0;
        hold_ready    = 1'b0;
        burst_active  = 1'b0;
        cycle_count   = '0;
        enabled_count = '0;

        repeat (4) @(posedge clock);
        rst_n <= 1'b1;

        // After reset the pipe is empty and ready for issue
        repeat (3) begin
            @(posedge clock);
            check_value("result_valid", 32'(result_valid), 32'd0);
            check_value("issue_ready", 32'(issue_ready), 32'd1);
        end

        // Corner operands for wraparound and signed compare
        directed_op(exec_pkg::OP_ADD, MAX_POS, 1, 0);
        directed_op(exec_pkg::OP_ADD, MIN_NEG, MIN_NEG, 0);
        directed_op(exec_pkg::OP_SUB, MIN_NEG, 1, 0);
        directed_op(exec_pkg::OP_SUB, 0, MAX_POS, 0);
        directed_op(exec_pkg::OP_AND, 32'shf0f0f0f0, 32'sh3c3c3c3c, 0);
        directed_op(exec_pkg::OP_OR, 32'shf0f0f0f0, 32'sh3c3c3c3c, 0);
        directed_op(exec_pkg::OP_XOR, 32'shf0f0f0f0, 32'sh3c3c3c3c, 0);
        directed_op(exec_pkg::OP_SLT, -1, 1, 0);
        directed_op(exec_pkg::OP_SLT, 1, -1, 0);
        directed_op(exec_pkg::OP_SLT, MIN_NEG, MAX_POS, 0);
        directed_op(exec_pkg::OP_SLT, MAX_POS, MAX_POS, 0);
        directed_op(exec_pkg::OP_MUL, MAX_POS, MAX_POS, 0);
        directed_op(exec_pkg::OP_MUL, MIN_NEG, -1, 0);
        directed_op(exec_pkg::OP_MUL, -3, 7, 0);
        directed_op(exec_pkg::OP_MAC, -3, 7, -100);
        directed_op(exec_pkg::OP_MAC, MAX_POS, 2, MAX_POS);
        // Undefined codes retire with a zero word
        directed_op(4'h8, 12345, 678, 9);
        directed_op(4'hf, -1, -1, -1);

        repeat (N_RANDOM) begin
            random_op(1'b1);
        end

        // Back-to-back burst with result_ready held high from an empty pipe
        hold_ready <= 1'b1;
        repeat (2) @(posedge clock);
        drain_results(DRAIN_CYCLES);
        burst_active <= 1'b1;
        repeat (N_BURST) begin
            random_op(1'b0);
        end
        burst_active <= 1'b0;
        drain_results(DRAIN_CYCLES);
        hold_ready <= 1'b0;

        drain_results(DRAIN_CYCLES);
        if (sb_queue.size() != 0) begin
            stop_with_failure($sformatf("%0d results are missing at the end of the run",
                                        sb_queue.size()));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/exec_core_props.sv
// Bound assertions on the exec_core handshake, stall and reset behaviour
`timescale 1ns/1ps
`default_nettype none

module exec_core_props (
    input wire                         clock,
    input wire                         rst_n,
    input wire                         issue_valid,
    input wire                         issue_ready,
    input wire                         result_valid,
    input wire                         result_ready,
    input wire exec_pkg::exec_result_t result
);

    // Accepted issues and enabled edges of the last few cycles with the newest in bit 0
    logic [exec_pkg::EXEC_LATENCY-1:0] accept_hist;
    logic [exec_pkg::EXEC_LATENCY-1:0] ready_hist;

    // Set by the first accepted issue after reset
    logic issued;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            accept_hist <= '0;
            ready_hist  <= '0;
            issued      <= 1'b0;
        end else begin
            accept_hist <= {accept_hist[exec_pkg::EXEC_LATENCY-2:0], issue_valid && issue_ready};
            ready_hist  <= {ready_hist[exec_pkg::EXEC_LATENCY-2:0], issue_ready};
            if (issue_valid && issue_ready) begin
                issued <= 1'b1;
            end
        end
    end

    // During reset the pipe empties and accepts issues
    reset_idle: assert property (@(posedge clock) !rst_n |=> !result_valid && issue_ready)
        else $error("Pipe not idle while reset is held");

    // Until the first issue after reset the pipe stays empty and ready
    after_reset_idle: assert property (@(posedge clock) disable iff (!rst_n)
        !issued |-> !result_valid && issue_ready)
        else $error("Pipe not idle before the first issue after reset");

    // A held result blocks the issue side
    stall_blocks_issue: assert property (@(posedge clock) disable iff (!rst_n)
        (result_valid && !result_ready) |-> !issue_ready)
        else $error("issue_ready high while the result is held");

    stall_holds_result: assert property (@(posedge clock) disable iff (!rst_n)
        (result_valid && !result_ready) |=> result_valid && $stable(result))
        else $error("Held result changed before it was taken");

    // An issue followed only by enabled edges reaches the output after the full depth
    issue_latency: assert property (@(posedge clock) disable iff (!rst_n)
        (accept_hist[exec_pkg::EXEC_LATENCY-1] && (&ready_hist[exec_pkg::EXEC_LATENCY-2:0]))
        |-> result_valid)
        else $error("No result after the pipeline depth of enabled cycles");

endmodule

bind exec_core exec_core_props u_exec_core_props (
    .clock        (clock),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
);

`default_nettype wire

//--- design/exec_core.sv
// Execution stage top level with issue/result handshake, global stall, tag line and both units
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  wire                        clock,
    input  wire                        rst_n,
    input  wire                        issue_valid,
    output logic                       issue_ready,
    input  wire exec_pkg::exec_issue_t issue,
    output logic                       result_valid,
    input  wire                        result_ready,
    output exec_pkg::exec_result_t     result
);

    // One enable advances every pipe in the core at the same time
    logic enable;

    // Opcode and destination of the incoming instruction
    exec_pkg::tag_t issue_tag;

    // Tag and occupancy at the end of the pipeline
    exec_pkg::tag_t out_tag;
    logic           out_valid;

    // Multiply-accumulate select decoded from the issue opcode
    logic accumulate;

    // Unit results aligned with out_tag
    exec_pkg::word_t alu_result;
    exec_pkg::word_t mul_result;

    // The pipe may move when the output stage is empty or being drained
    // result_valid is a register output, so there is no combinational loop
    assign enable      = !result_valid || result_ready;
    assign issue_ready = enable;

    assign issue_tag.opcode = issue.opcode;
    assign issue_tag.dest   = issue.dest;

    assign accumulate = (issue.opcode == exec_pkg::OP_MAC);

    // Tag line carries the only occupancy record of the pipeline
    // An enabled cycle without issue_valid shifts in a bubble
    stream_delay #(
        .payload_t (exec_pkg::tag_t),
        .depth     (exec_pkg::EXEC_LATENCY)
    ) u_tag_line (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .in_valid  (issue_valid),
        .in_data   (issue_tag),
        .out_valid (out_valid),
        .out_data  (out_tag)
    );

    // Both units see every instruction and compute in parallel
    add_logic_unit u_add_logic (
        .clock  (clock),
        .rst_n  (rst_n),
        .enable (enable),
        .opcode (issue.opcode),
        .a      (issue.a),
        .b      (issue.b),
        .result (alu_result)
    );

    mul_unit u_mul (
        .clock      (clock),
        .rst_n      (rst_n),
        .enable     (enable),
        .accumulate (accumulate),
        .a          (issue.a),
        .b          (issue.b),
        .c          (issue.c),
        .result     (mul_result)
    );

    // Delayed opcode picks the unit that owns this instruction
    result_select u_select (
        .tag          (out_tag),
        .valid        (out_valid),
        .alu_result   (alu_result),
        .mul_result   (mul_result),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

//--- design/result_select.sv
// Result multiplexer driven by the delayed opcode, building the tagged result word
`timescale 1ns/1ps
`default_nettype none

module result_select (
    input  wire exec_pkg::tag_t  tag,
    input  wire                  valid,
    input  wire exec_pkg::word_t alu_result,
    input  wire exec_pkg::word_t mul_result,
    output exec_pkg::exec_result_t result,
    output logic                 result_valid
);

    // Both units and the tag line already line up at the output depth
    always_comb begin
        // Destination always comes straight from the tag
        result.dest = tag.dest;

        case (tag.opcode)
            // Adder/logic subset
            exec_pkg::OP_ADD,
            exec_pkg::OP_SUB,
            exec_pkg::OP_AND,
            exec_pkg::OP_OR,
            exec_pkg::OP_XOR,
            exec_pkg::OP_SLT: begin
                result.data = alu_result;
            end

            // Multiplier subset
            exec_pkg::OP_MUL,
            exec_pkg::OP_MAC: begin
                result.data = mul_result;
            end

            // Undefined codes still retire with a zero word
            default: begin
                result.data = '0;
            end
        endcase
    end

    // Output valid is the final valid bit of the tag line
    assign result_valid = valid;

endmodule

`default_nettype wire

//--- design/mul_unit.sv
// Two-stage signed 32x32 multiplier with optional accumulate, padded to the common depth
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 enable,
    input  wire                 accumulate,
    input  wire exec_pkg::word_t a,
    input  wire exec_pkg::word_t b,
    input  wire exec_pkg::word_t c,
    output exec_pkg::word_t      result
);

    // Full signed product at twice the word width
    logic signed [2*exec_pkg::WORD_WIDTH-1:0] prod_q;

    // Addend and accumulate flag follow the product into stage two
    exec_pkg::word_t c_q;
    logic            acc_q;

    // Stage two output that feeds the padding line
    exec_pkg::word_t mul_q;

    // Stage one registers the product
    // Both operands are signed and the target is 64 bits wide, so they are
    // sign extended before the multiply
    always_ff @(posedge clock) begin
        if (enable) begin
            prod_q <= a * b;
            c_q    <= c;
            acc_q  <= accumulate;
        end
    end

    // Stage two keeps the low word and adds c for multiply-accumulate
    // The sum wraps like any other word result
    always_ff @(posedge clock) begin
        if (enable) begin
            if (acc_q) begin
                mul_q <= exec_pkg::word_t'(prod_q[exec_pkg::WORD_WIDTH-1:0]) + c_q;
            end else begin
                mul_q <= exec_pkg::word_t'(prod_q[exec_pkg::WORD_WIDTH-1:0]);
            end
        end
    end

    // Remaining stages are delay only
    // The tag line in the top level records occupancy, so the valid
    // chain here is fed with ones and its output is not needed
    stream_delay #(
        .payload_t (exec_pkg::word_t),
        .depth     (exec_pkg::EXEC_LATENCY - exec_pkg::MUL_STAGES)
    ) u_mul_pad (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .in_valid  (1'b1),
        .in_data   (mul_q),
        .out_valid (),
        .out_data  (result)
    );

endmodule

`default_nettype wire

//--- design/add_logic_unit.sv
// Adder, subtractor, bitwise logic and signed compare, padded to the common pipeline depth
`timescale 1ns/1ps
`default_nettype none

module add_logic_unit (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire                   enable,
    input  wire exec_pkg::opcode_t opcode,
    input  wire exec_pkg::word_t   a,
    input  wire exec_pkg::word_t   b,
    output exec_pkg::word_t        result
);

    // Combinational outcome for this cycle's opcode
    exec_pkg::word_t alu_next;

    // First register stage of the unit
    exec_pkg::word_t alu_q;

    always_comb begin
        unique case (opcode)
            // Add and subtract simply wrap on overflow
            exec_pkg::OP_ADD: begin
                alu_next = a + b;
            end
            exec_pkg::OP_SUB: begin
                alu_next = a - b;
            end
            exec_pkg::OP_AND: begin
                alu_next = a & b;
            end
            exec_pkg::OP_OR: begin
                alu_next = a | b;
            end
            exec_pkg::OP_XOR: begin
                alu_next = a ^ b;
            end
            // Both operands are signed words, so this is a signed compare
            exec_pkg::OP_SLT: begin
                alu_next = (a < b) ? exec_pkg::word_t'(1) : exec_pkg::word_t'(0);
            end
            // Multiplier codes and undefined codes leave this unit at zero
            default: begin
                alu_next = '0;
            end
        endcase
    end

    // Stage 0 of the unit loads together with stage 0 of the tag line
    always_ff @(posedge clock) begin
        if (enable) begin
            alu_q <= alu_next;
        end
    end

    // The rest of the depth is plain delay so the word lines up with its tag
    // Occupancy lives in the tag line, so the valid chain here is only
    // filled with ones and its output is left open
    stream_delay #(
        .payload_t (exec_pkg::word_t),
        .depth     (exec_pkg::EXEC_LATENCY - exec_pkg::ALU_STAGES)
    ) u_alu_pad (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .in_valid  (1'b1),
        .in_data   (alu_q),
        .out_valid (),
        .out_data  (result)
    );

endmodule

`default_nettype wire

//--- design/stream_delay.sv
// Stallable fixed-depth delay line for any payload type with one valid bit per stage
`timescale 1ns/1ps
`default_nettype none

module stream_delay #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  wire      clock,
    input  wire      rst_n,
    input  wire      enable,
    input  wire      in_valid,
    input  wire      payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Stage 0 takes the input, stage depth-1 feeds the output
    payload_t         data_q [depth];
    logic [depth-1:0] valid_q;

    // Valid bits clear on reset and move one stage per enabled edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < depth; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload shifts in lock step with the valid bits
    // A stage whose valid bit is low carries a don't-care payload
    always_ff @(posedge clock) begin
        if (enable) begin
            data_q[0] <= in_data;
            for (int i = 1; i < depth; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end
    end

    // When enable is low every stage holds, so the output is stable
    assign out_valid = valid_q[depth-1];
    assign out_data  = data_q[depth-1];

endmodule

`default_nettype wire

//--- design/exec_pkg.sv
// Shared word, opcode, tag, issue and result types, opcode codes and pipeline depths
`default_nettype none

package exec_pkg;

    // Width of one data word and of a destination register address
    localparam int WORD_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 4;

    // Enabled cycles from an accepted issue to the result at the outputs
    localparam int EXEC_LATENCY = 4;

    // Register stages inside each unit before the padding delay line
    localparam int ALU_STAGES = 1;
    localparam int MUL_STAGES = 2;

    // Operands and results are signed two's complement words
    typedef logic signed [WORD_WIDTH-1:0] word_t;

    typedef logic [3:0] opcode_t;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Adder/logic unit subset
    localparam opcode_t OP_ADD = 4'h0;
    localparam opcode_t OP_SUB = 4'h1;
    localparam opcode_t OP_AND = 4'h2;
    localparam opcode_t OP_OR  = 4'h3;
    localparam opcode_t OP_XOR = 4'h4;
    localparam opcode_t OP_SLT = 4'h5;

    // Multiplier unit subset
    // Codes 4'h8 to 4'hf have no operation and give a zero result
    localparam opcode_t OP_MUL = 4'h6;
    localparam opcode_t OP_MAC = 4'h7;

    // Opcode and destination travel down the tag line next to the data
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t dest;
    } tag_t;

    // One instruction as it arrives on the issue stream
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t dest;
        word_t     a;
        word_t     b;
        word_t     c;
    } exec_issue_t;

    // One result word on the result stream together with its destination
    typedef struct packed {
        reg_addr_t dest;
        word_t     data;
    } exec_result_t;

endpackage

`default_nettype wire
